// File: all.f
+incdir+dv
src/fault_mon_pkg.sv
src/csr_access_if.sv
src/op_classifier.sv
src/class_counter_bank.sv
src/csr_port.sv
src/alu_fault_monitor.sv
dv/alu_fault_monitor_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ALU fault monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module alu_fault_monitor_tb \
  -o alu_fault_monitor_sim \
  && ./obj_dir/alu_fault_monitor_sim > sim.log \
  || { echo "Build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// File: dv/fault_model.svh
`ifndef FAULT_MODEL_SVH
`define FAULT_MODEL_SVH

// Expected counters and fault map in step with the DUT registers
int               m_cnt [N_CNT];
logic [N_CNT-1:0] m_fault;

// Reports as registered one edge earlier
logic m_ev_valid [N_ALU];
int   m_ev_cls [N_ALU];
logic m_ev_err [N_ALU];

// Class number of an operator code, or -1 for codes never counted
function automatic int op_class(input int op);
  if (op >= 1 && op <= 5) return 0;
  if (op >= 6 && op <= 8) return 1;
  if (op >= 9 && op <= 12) return 2;
  if (op >= 13 && op <= 16) return 3;
  return -1;
endfunction

function automatic void model_reset();
  m_fault = '0;
  for (int i = 0; i < N_CNT; i++) begin
    m_cnt[i] = 0;
  end
  for (int a = 0; a < N_ALU; a++) begin
    m_ev_valid[a] = 1'b0;
    m_ev_cls[a]   = 0;
    m_ev_err[a]   = 1'b0;
  end
endfunction

// One rising edge of the monitor
function automatic void model_edge();
  logic [N_CNT-1:0] new_faults;
  logic             wr_ok;
  int               idx;
  int               nxt;
  int               cls;
  new_faults = '0;
  wr_ok      = csr_we && !csr_re;
  // Leaky step from last edge's events
  for (int a = 0; a < N_ALU; a++) begin
    idx = a * N_CLASS + m_ev_cls[a];
    if (m_ev_valid[a] && !m_fault[idx]) begin
      if (m_ev_err[a]) begin
        // Errors saturate at the threshold
        nxt = m_cnt[idx] + ERR_INCREASE;
        if (nxt > ERR_THRESHOLD) nxt = ERR_THRESHOLD;
      end else begin
        nxt = m_cnt[idx] - ERR_DECREASE;
        if (nxt < 0) nxt = 0;
      end
      // Reaching the threshold declares the fault and restarts from 0
      if (nxt == ERR_THRESHOLD) begin
        new_faults[idx] = 1'b1;
        nxt             = 0;
      end
      m_cnt[idx] = nxt;
    end
  end
  // Faulty classes sit at 0
  for (int i = 0; i < N_CNT; i++) begin
    if (m_fault[i]) m_cnt[i] = 0;
  end
  // CSR writes override
  if (wr_ok && int'(csr_addr) < N_CNT) m_cnt[int'(csr_addr)] = int'(csr_wdata[CNT_W-1:0]);
  if (wr_ok && int'(csr_addr) == ADDR_FAULT_MAP) begin
    m_fault = csr_wdata[N_CNT-1:0];
  end else begin
    m_fault = m_fault | new_faults;
  end
  // Register this edge's reports
  for (int a = 0; a < N_ALU; a++) begin
    cls           = op_class(int'(alu_op[a]));
    m_ev_valid[a] = alu_valid[a] && (cls >= 0) && (cls != 3 || div_done);
    m_ev_cls[a]   = (cls < 0) ? 0 : cls;
    m_ev_err[a]   = alu_error[a];
  end
endfunction

// Expected read data for one address
function automatic logic [DATA_W-1:0] model_read(input int addr);
  if (addr < N_CNT) return DATA_W'(m_cnt[addr]);
  if (addr == ADDR_FAULT_MAP) return DATA_W'(m_fault);
  return '0;
endfunction

`endif

// File: dv/alu_fault_monitor_tb.sv
`timescale 1ns/100ps

module alu_fault_monitor_tb import fault_mon_pkg::*; ();

  logic                clock_gated;
  logic                rst_n;
  logic [N_ALU-1:0]    alu_valid;
  alu_op_e [N_ALU-1:0] alu_op;
  logic [N_ALU-1:0]    alu_error;
  logic                div_done;
  logic [ADDR_W-1:0]   csr_addr;
  logic                csr_re;
  logic                csr_we;
  logic [DATA_W-1:0]   csr_wdata;
  logic [DATA_W-1:0]   csr_rdata;
  logic [N_CNT-1:0]    fault_map;
  int                  seed;
  int                  errors;
  int                  tests;
  int                  failed_tests;
  int                  err_start;
  int                  waited;

  `include "fault_model.svh"

  alu_fault_monitor i_alu_fault_monitor (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .alu_valid_i (alu_valid),
    .alu_op_i    (alu_op),
    .alu_error_i (alu_error),
    .div_done_i  (div_done),
    .csr_addr_i  (csr_addr),
    .csr_re_i    (csr_re),
    .csr_we_i    (csr_we),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .fault_map_o (fault_map)
  );

  // 10 ns clock
  initial clock_gated = 1'b0;
  always #5 clock_gated = ~clock_gated;

  // Model follows the DUT edge by edge
  always @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      model_edge();
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic set_idle();
    alu_valid = '0;
    alu_op    = {N_ALU{OP_NOP}};
    alu_error = '0;
    div_done  = 1'b0;
    csr_addr  = '0;
    csr_re    = 1'b0;
    csr_we    = 1'b0;
    csr_wdata = '0;
  endtask

  task automatic check_value(input string sig, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h at %0t", sig, got, exp, $time);
      errors++;
    end
  endtask

  // One report on one ALU for a cycle
  task automatic report_cycle(input int alu, input alu_op_e op, input logic err,
                              input logic done);
    @(negedge clock_gated);
    set_idle();
    alu_valid[alu] = 1'b1;
    alu_op[alu]    = op;
    alu_error[alu] = err;
    div_done       = done;
  endtask

  // All four ALUs with errors about 1 in 4
  task automatic random_reports();
    int addr;
    @(negedge clock_gated);
    set_idle();
    for (int a = 0; a < N_ALU; a++) begin
      alu_valid[a] = rand_below(2) != 0;
      alu_op[a]    = alu_op_e'(OP_W'(rand_below(18)));
      alu_error[a] = rand_below(4) == 0;
    end
    div_done = rand_below(2) != 0;
    // One random address and the fault map checked in every report cycle
    addr     = rand_below(2 ** ADDR_W);
    csr_re   = 1'b1;
    csr_addr = ADDR_W'(addr);
    #2;
    check_value("csr_rdata_o", csr_rdata, model_read(addr));
    check_value("fault_map_o", DATA_W'(fault_map), DATA_W'(m_fault));
  endtask

  task automatic csr_write(input int addr, input logic [DATA_W-1:0] data, input logic re);
    @(negedge clock_gated);
    set_idle();
    csr_we    = 1'b1;
    csr_re    = re;
    csr_addr  = ADDR_W'(addr);
    csr_wdata = data;
  endtask

  // Read one address mid cycle and compare with the model
  task automatic check_read(input int addr);
    @(negedge clock_gated);
    set_idle();
    csr_re   = 1'b1;
    csr_addr = ADDR_W'(addr);
    #2;
    check_value("csr_rdata_o", csr_rdata, model_read(addr));
    check_value("fault_map_o", DATA_W'(fault_map), DATA_W'(m_fault));
  endtask

  task automatic read_all();
    for (int addr = 0; addr < 2 ** ADDR_W; addr++) begin
      check_read(addr);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != err_start) failed_tests++;
    $display("Test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "FAILED");
    err_start = errors;
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    seed      = 32'h33d;
    errors    = 0;
    tests     = 0;
    failed_tests = 0;
    err_start = 0;
    rst_n     = 1'b0;
    set_idle();
    model_reset();
    repeat (4) @(posedge clock_gated);
    @(negedge clock_gated);
    rst_n = 1'b1;

    read_all();
    end_test("reset values");

    // Short bursts followed by a full readback
    repeat (100) begin
      repeat (1 + rand_below(3)) random_reports();
      read_all();
    end
    end_test("random reports");

    // Clean start for the ALU 2 compare counter at index 10
    csr_write(ADDR_FAULT_MAP, '0, 1'b0);
    csr_write(10, '0, 1'b0);
    repeat (4) report_cycle(2, OP_EQ, 1'b1, 1'b0);
    waited = 0;
    while (!fault_map[10] && waited < 20) begin
      @(negedge clock_gated);
      set_idle();
      #2;
      waited++;
    end
    assert (fault_map[10]) else begin
      $display("Timeout waiting for fault bit 10");
      errors++;
    end
    assert (waited == 2) else begin
      $display("Fault bit 10 set %0d cycles after the last report, expected 2", waited);
      errors++;
    end
    check_value("fault_map_o", DATA_W'(fault_map), 32'h0000_0400);
    report_cycle(2, OP_EQ, 1'b1, 1'b0);
    read_all();
    check_read(10);
    check_value("csr_rdata_o", csr_rdata, '0);
    end_test("threshold fault");

    csr_write(5, 32'h07, 1'b0);
    check_read(5);
    check_value("csr_rdata_o", csr_rdata, 32'h07);
    // Event and write land on counter 5 at the same edge
    report_cycle(1, OP_XOR, 1'b1, 1'b0);
    csr_write(5, 32'h02, 1'b0);
    // Read data stays 0 without read enable
    #2;
    check_value("csr_rdata_o", csr_rdata, '0);
    check_read(5);
    check_value("csr_rdata_o", csr_rdata, 32'h02);
    csr_write(5, 32'h09, 1'b1);
    #2;
    check_value("csr_rdata_o", csr_rdata, 32'h02);
    check_read(5);
    check_value("csr_rdata_o", csr_rdata, 32'h02);
    // Clean event drains a written value above the threshold by one
    csr_write(5, 32'h20, 1'b0);
    report_cycle(1, OP_AND, 1'b0, 1'b0);
    read_all();
    check_read(5);
    check_value("csr_rdata_o", csr_rdata, 32'h1f);
    end_test("counter writes");

    csr_write(ADDR_FAULT_MAP, '0, 1'b0);
    check_read(ADDR_FAULT_MAP);
    check_value("fault_map_o", DATA_W'(fault_map), '0);
    repeat (2) report_cycle(2, OP_NE, 1'b1, 1'b0);
    read_all();
    check_read(10);
    check_value("csr_rdata_o", csr_rdata, 32'h06);
    repeat (20) begin
      random_reports();
      read_all();
    end
    end_test("fault map clear");

    $display("Tests: %0d run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Stops a run that never reaches the end
  initial begin
    #500000;
    $display("Watchdog expired before the test sequence ended");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: src/alu_fault_monitor.sv
`timescale 1ns/100ps

module alu_fault_monitor import fault_mon_pkg::*; (
  input  logic                clock_gated,
  input  logic                rst_n,

  // ALU result reports
  input  logic [N_ALU-1:0]    alu_valid_i,
  input  alu_op_e [N_ALU-1:0] alu_op_i,
  input  logic [N_ALU-1:0]    alu_error_i,
  input  logic                div_done_i,

  // Local CSR access
  input  logic [ADDR_W-1:0]   csr_addr_i,
  input  logic                csr_re_i,
  input  logic                csr_we_i,
  input  logic [DATA_W-1:0]   csr_wdata_i,
  output logic [DATA_W-1:0]   csr_rdata_o,

  // Permanent fault per ALU and class
  output logic [N_CNT-1:0]    fault_map_o
);

  // Registered, classified reports
  alu_event_t [N_ALU-1:0] events;

  // Write strobes down, counter state up
  csr_access_if csr_bus ();

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  op_classifier i_op_classifier (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .alu_valid_i (alu_valid_i),
    .alu_op_i    (alu_op_i),
    .alu_error_i (alu_error_i),
    .div_done_i  (div_done_i),
    .events_o    (events)
  );

  ////////////////////////////////////////
  // Counters and fault map
  ////////////////////////////////////////

  class_counter_bank i_class_counter_bank (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .events_i    (events),
    .csr         (csr_bus.bank)
  );

  ////////////////////////////////////////
  // CSR side
  ////////////////////////////////////////

  csr_port i_csr_port (
    .csr_addr_i  (csr_addr_i),
    .csr_re_i    (csr_re_i),
    .csr_we_i    (csr_we_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .csr         (csr_bus.port)
  );

  // Sticky map also goes out directly
  assign fault_map_o = csr_bus.fault_map;

endmodule

// File: src/csr_port.sv
`timescale 1ns/100ps

module csr_port import fault_mon_pkg::*; (
  input  logic [ADDR_W-1:0] csr_addr_i,
  input  logic              csr_re_i,
  input  logic              csr_we_i,
  input  logic [DATA_W-1:0] csr_wdata_i,
  output logic [DATA_W-1:0] csr_rdata_o,
  csr_access_if.port        csr
);

  logic     sel_cnt;
  logic     sel_map;
  logic     mapped;
  counter_t rd_cnt;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Low half of the space holds the counters
  assign sel_cnt = (csr_addr_i < ADDR_W'(N_CNT));
  assign sel_map = (csr_addr_i == ADDR_W'(ADDR_FAULT_MAP));
  assign mapped  = sel_cnt || sel_map;

  // Counter index is the address itself
  assign rd_cnt = csr.cnt_values[csr_addr_i[CNT_IDX_W-1:0]];

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  // Zero unless a read to a mapped address
  always_comb begin
    csr_rdata_o = '0;
    if (csr_re_i) begin
      if (sel_cnt) begin
        csr_rdata_o = DATA_W'(rd_cnt);
      end else if (sel_map) begin
        csr_rdata_o = DATA_W'(csr.fault_map);
      end
    end
  end

  ////////////////////////////////////////
  // Write strobe
  ////////////////////////////////////////

  // Read has priority, write dropped in that cycle
  assign csr.wr_en   = csr_we_i && !csr_re_i && mapped;
  assign csr.wr_map  = sel_map;
  assign csr.wr_idx  = csr_addr_i[CNT_IDX_W-1:0];
  // Bank takes the low bits it needs
  assign csr.wr_data = csr_wdata_i;

endmodule

// File: src/class_counter_bank.sv
`timescale 1ns/100ps

module class_counter_bank import fault_mon_pkg::*; (
  input  logic                   clock_gated,
  input  logic                   rst_n,
  input  alu_event_t [N_ALU-1:0] events_i,
  csr_access_if.bank             csr
);

  // One spare bit so the error step cannot wrap
  localparam int SUM_W = CNT_W + 1;

  counter_t [N_CNT-1:0] cnt_q;
  counter_t             cnt_n [N_CNT];
  logic [N_CNT-1:0]     fault_q;
  logic [N_CNT-1:0]     fault_set;
  logic [N_CNT-1:0]     fault_n;
  logic                 map_wr;

  ////////////////////////////////////////
  // Leaky step
  ////////////////////////////////////////

  // Error adds, clean op drains; capped at threshold, floored at 0
  function automatic counter_t leak_step(input counter_t cnt, input logic err);
    logic [SUM_W-1:0] sum;
    counter_t         res;
    sum = {1'b0, cnt} + SUM_W'(ERR_INCREASE);
    if (err) begin
      if (sum >= SUM_W'(ERR_THRESHOLD)) begin
        res = counter_t'(ERR_THRESHOLD);
      end else begin
        res = sum[CNT_W-1:0];
      end
    end else if (cnt >= counter_t'(ERR_DECREASE)) begin
      res = cnt - counter_t'(ERR_DECREASE);
    end else begin
      res = '0;
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Per counter next state
  ////////////////////////////////////////

  for (genvar a = 0; a < N_ALU; a++) begin : g_alu
    for (genvar c = 0; c < N_CLASS; c++) begin : g_cls
      localparam int IDX = a * N_CLASS + c;

      logic     hit;
      logic     cnt_wr;
      logic     reach;
      counter_t step_val;

      // At most one event per ALU, so one hit per counter
      assign hit      = events_i[a].valid && (events_i[a].cls == alu_class_e'(c));
      assign step_val = leak_step(cnt_q[IDX], events_i[a].error);
      assign reach    = hit && (step_val == counter_t'(ERR_THRESHOLD));
      assign cnt_wr   = csr.wr_en && !csr.wr_map && (csr.wr_idx == CNT_IDX_W'(IDX));

      // Threshold hit goes to the fault map
      assign fault_set[IDX] = reach;

      always_comb begin
        if (cnt_wr) begin
          // CSR write beats the event
          cnt_n[IDX] = csr.wr_data[CNT_W-1:0];
        end else if (fault_q[IDX] || reach) begin
          // Faulty class parks at 0, also cleared on declaring the fault
          cnt_n[IDX] = '0;
        end else if (hit) begin
          cnt_n[IDX] = step_val;
        end else begin
          cnt_n[IDX] = cnt_q[IDX];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Fault map
  ////////////////////////////////////////

  assign map_wr = csr.wr_en && csr.wr_map;

  // Sticky bits; a map write replaces everything, new sets included
  assign fault_n = map_wr ? csr.wr_data[N_CNT-1:0] : (fault_q | fault_set);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      fault_q <= '0;
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= cnt_n[i];
      end
      fault_q <= fault_n;
    end
  end

  // Read side, straight from the registers
  assign csr.cnt_values = cnt_q;
  assign csr.fault_map  = fault_q;

endmodule

// File: src/op_classifier.sv
`timescale 1ns/100ps

module op_classifier import fault_mon_pkg::*; (
  input  logic                   clock_gated,
  input  logic                   rst_n,
  input  logic [N_ALU-1:0]       alu_valid_i,
  input  alu_op_e [N_ALU-1:0]    alu_op_i,
  input  logic [N_ALU-1:0]       alu_error_i,
  input  logic                   div_done_i,
  output alu_event_t [N_ALU-1:0] events_o
);

  alu_event_t [N_ALU-1:0] events_d;
  alu_event_t [N_ALU-1:0] events_q;

  ////////////////////////////////////////
  // Operator decode
  ////////////////////////////////////////

  // Maps one report to an event, invalid when it must not be counted
  function automatic alu_event_t classify(
    input logic    valid,
    input alu_op_e op,
    input logic    err,
    input logic    div_done
  );
    alu_event_t ev;
    logic       known;
    known    = 1'b1;
    ev.cls   = CLS_ARITH;
    ev.error = err;
    case (op)
      // Adder and shifter share a class
      OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA: ev.cls = CLS_ARITH;
      OP_XOR, OP_OR, OP_AND:                  ev.cls = CLS_LOGIC;
      OP_LTS, OP_LTU, OP_EQ, OP_NE:           ev.cls = CLS_CMP;
      // Multi-cycle divider, result only counts once done
      OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
        ev.cls = CLS_DIV;
        known  = div_done;
      end
      // NOP and unused codes
      default: known = 1'b0;
    endcase
    ev.valid = valid && known;
    return ev;
  endfunction

  always_comb begin
    for (int a = 0; a < N_ALU; a++) begin
      events_d[a] = classify(alu_valid_i[a], alu_op_i[a], alu_error_i[a], div_done_i);
    end
  end

  ////////////////////////////////////////
  // Event register
  ////////////////////////////////////////

  // One cycle into the bank
  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      events_q <= '0;
    end else begin
      events_q <= events_d;
    end
  end

  assign events_o = events_q;

endmodule

// File: src/csr_access_if.sv
`timescale 1ns/100ps

interface csr_access_if import fault_mon_pkg::*; ();

  // Write strobe, single cycle
  logic                 wr_en;
  // High selects the fault map, low a counter
  logic                 wr_map;
  logic [CNT_IDX_W-1:0] wr_idx;
  logic [DATA_W-1:0]    wr_data;

  // Live state of the bank for the read mux
  counter_t [N_CNT-1:0] cnt_values;
  logic [N_CNT-1:0]     fault_map;

  // CSR side
  modport port (
    output wr_en, wr_map, wr_idx, wr_data,
    input  cnt_values, fault_map
  );

  // Counter bank side
  modport bank (
    input  wr_en, wr_map, wr_idx, wr_data,
    output cnt_values, fault_map
  );

endinterface

// File: src/fault_mon_pkg.sv
package fault_mon_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Monitored ALUs and operation classes
  localparam int N_ALU   = 4;
  localparam int N_CLASS = 4;
  localparam int CLASS_W = $clog2(N_CLASS);

  // One counter per ALU and class pair
  localparam int N_CNT     = N_ALU * N_CLASS;
  localparam int CNT_IDX_W = $clog2(N_CNT);
  localparam int CNT_W     = 8;

  // Operator code width
  localparam int OP_W = 5;

  // Local CSR space
  localparam int ADDR_W         = 5;
  localparam int DATA_W         = 32;
  localparam int ADDR_FAULT_MAP = 16;

  ////////////////////////////////////////
  // Leaky counter tuning
  ////////////////////////////////////////

  // Count at which a class is declared permanently faulty
  localparam int ERR_THRESHOLD = 12;
  // Step up per detected error
  localparam int ERR_INCREASE  = 3;
  // Step down per clean operation
  localparam int ERR_DECREASE  = 1;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Operators reported by the ALUs
  typedef enum logic [OP_W-1:0] {
    OP_NOP  = 5'd0,
    OP_ADD  = 5'd1,
    OP_SUB  = 5'd2,
    OP_SLL  = 5'd3,
    OP_SRL  = 5'd4,
    OP_SRA  = 5'd5,
    OP_XOR  = 5'd6,
    OP_OR   = 5'd7,
    OP_AND  = 5'd8,
    OP_LTS  = 5'd9,
    OP_LTU  = 5'd10,
    OP_EQ   = 5'd11,
    OP_NE   = 5'd12,
    OP_DIV  = 5'd13,
    OP_DIVU = 5'd14,
    OP_REM  = 5'd15,
    OP_REMU = 5'd16
  } alu_op_e;

  // Operation classes, also the low part of the counter index
  typedef enum logic [CLASS_W-1:0] {
    CLS_ARITH = 2'd0,
    CLS_LOGIC = 2'd1,
    CLS_CMP   = 2'd2,
    CLS_DIV   = 2'd3
  } alu_class_e;

  typedef logic [CNT_W-1:0] counter_t;

  // Classified report of one ALU
  typedef struct packed {
    logic       valid;
    alu_class_e cls;
    logic       error;
  } alu_event_t;

endpackage
